// File: common/booth_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// booth_if: contents of one booth pipeline stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "exec_params.svh"

interface booth_if;
  logic                   valid;
  logic                   is_mul;      // item uses the accumulator result
  logic [`REG_ADDR_W-1:0] rd;
  logic [`ACC_W-1:0]      acc;         // partial product, upper word + sign on top
  logic [`XLEN-1:0]       mcand;
  logic [`XLEN-1:0]       mplier;      // shifted right one bit per step
  logic                   prev_bit;    // last multiplier bit consumed
  logic [`XLEN-1:0]       alu_result;  // result of non-multiply ops

  // stage register side
  modport up (output valid, is_mul, rd, acc, mcand, mplier, prev_bit, alu_result);

  // consuming stage side
  modport down (input valid, is_mul, rd, acc, mcand, mplier, prev_bit, alu_result);
endinterface

// File: common/exec_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// width and depth constants for the integer execute block
// data word, register address, booth step count, accumulator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// data word width
`define XLEN 32

// register address width, 32 architectural registers
`define REG_ADDR_W 5

// one booth step per multiplier bit
`define BOOTH_STEPS 32

// accumulator is sign bit + upper word + lower word
`define ACC_W (2 * `XLEN + 1)

`endif

// File: common/exec_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the execute block
// major opcode and decoded alu operation enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package exec_pkg;

  // major opcodes accepted by the decoder, everything else is dropped
  typedef enum logic [6:0] {
    OP_COMPUTE = 7'b0110011,  // register-register
    OP_IMM     = 7'b0010011   // register-immediate
  } opcode_e;

  // operation chosen from funct3 and funct7
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_MUL  = 4'd10  // low word of signed product, via booth pipe
  } alu_op_e;

endpackage

// File: exec_unit.f
+incdir+common
common/exec_pkg.sv
common/booth_if.sv
execute/op_decode.sv
execute/booth_step.sv
execute/result_writeback.sv
verilog/exec_unit_top.sv
tests/tb_exec_unit.sv

// File: execute/booth_step.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// booth_step: one registered radix-2 booth iteration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "exec_params.svh"

module booth_step (
  input  logic   clk,
  input  logic   reset,
  booth_if.down  stage_in,
  booth_if.up    stage_out
);

  logic [`ACC_W-1:0] addend;
  logic [`ACC_W-1:0] acc_sum;

  // multiplicand sign extended into the upper word
  assign addend = {stage_in.mcand[`XLEN-1], stage_in.mcand, {`XLEN{1'b0}}};

  always_comb
  begin
    case ({stage_in.mplier[0], stage_in.prev_bit})
      2'b10:   acc_sum = stage_in.acc - addend;  // start of a run of ones
      2'b01:   acc_sum = stage_in.acc + addend;  // end of a run
      default: acc_sum = stage_in.acc;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      stage_out.valid <= 1'b0;
    else
      stage_out.valid <= stage_in.valid;
  end

  always_ff @(posedge clk)
  begin
    stage_out.is_mul     <= stage_in.is_mul;
    stage_out.rd         <= stage_in.rd;
    stage_out.mcand      <= stage_in.mcand;
    stage_out.alu_result <= stage_in.alu_result;
    if (stage_in.is_mul)
    begin
      stage_out.acc      <= {acc_sum[`ACC_W-1], acc_sum[`ACC_W-1:1]};  // arithmetic shift
      stage_out.mplier   <= stage_in.mplier >> 1;
      stage_out.prev_bit <= stage_in.mplier[0];
    end
    else
    begin
      stage_out.acc      <= stage_in.acc;
      stage_out.mplier   <= stage_in.mplier;
      stage_out.prev_bit <= stage_in.prev_bit;
    end
  end

endmodule

// File: execute/op_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// op_decode: instruction decode, operand select and alu
// seeds the booth accumulator for multiplies
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "exec_params.svh"

module op_decode (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  input  logic [`XLEN-1:0]  inst,
  input  logic [`XLEN-1:0]  rs1_data,
  input  logic [`XLEN-1:0]  rs2_data,
  booth_if.up               stage_out
);
  import exec_pkg::*;

  logic             op_ok;    // opcode is one we execute
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;
  alu_op_e          alu_op;
  logic [`XLEN-1:0] alu_out;

  // operand selection
  always_comb
  begin
    op_ok  = 1'b0;
    funct3 = inst[14:12];
    funct7 = inst[31:25];
    op_a   = rs1_data;
    op_b   = rs2_data;
    case (inst[6:0])
      OP_COMPUTE:
      begin
        op_ok = 1'b1;
      end
      OP_IMM:
      begin
        op_ok = 1'b1;
        if (funct3 == 3'b001 || funct3 == 3'b101)
        begin
          // shift immediates, funct7 lives in the upper imm bits
          op_b = {{(`XLEN-5){1'b0}}, inst[24:20]};
        end
        else
        begin
          funct7 = 7'b0000000;  // no sub or mul for immediates
          op_b   = {{(`XLEN-12){inst[31]}}, inst[31:20]};
        end
      end
      default:
      begin
        op_ok = 1'b0;
      end
    endcase
  end

  // operation select, sub wins over mul when both bits are set
  always_comb
  begin
    case (funct3)
      3'b000:  alu_op = funct7[5] ? ALU_SUB : (funct7[0] ? ALU_MUL : ALU_ADD);
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  assign shamt = op_b[4:0];  // only the low 5 bits shift

  always_comb
  begin
    case (alu_op)
      ALU_ADD:  alu_out = op_a + op_b;
      ALU_SUB:  alu_out = op_a - op_b;
      ALU_SLL:  alu_out = op_a << shamt;
      ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_SRL:  alu_out = op_a >> shamt;
      ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
      ALU_OR:   alu_out = op_a | op_b;
      ALU_AND:  alu_out = op_a & op_b;
      default:  alu_out = '0;  // product comes out of the booth pipe
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      stage_out.valid <= 1'b0;
    else
      stage_out.valid <= in_valid && op_ok;
  end

  // payload of stage 0
  always_ff @(posedge clk)
  begin
    stage_out.is_mul     <= (alu_op == ALU_MUL);
    stage_out.rd         <= inst[11:7];
    stage_out.acc        <= '0;
    stage_out.mcand      <= op_a;
    stage_out.mplier     <= op_b;
    stage_out.prev_bit   <= 1'b0;  // implied bit right of the lsb
    stage_out.alu_result <= alu_out;
  end

endmodule

// File: execute/result_writeback.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result_writeback: result select, x0 rule, output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "exec_params.svh"

module result_writeback (
  input  logic                   clk,
  input  logic                   reset,
  booth_if.down                  stage_in,
  output logic                   out_valid,
  output logic [`REG_ADDR_W-1:0] out_rd,
  output logic [`XLEN-1:0]       out_data
);

  logic [`XLEN-1:0] wb_data;

  always_comb
  begin
    if (stage_in.rd == '0)
      wb_data = '0;  // x0 reads as zero
    else if (stage_in.is_mul)
      wb_data = stage_in.acc[`XLEN-1:0];  // low word of the product
    else
      wb_data = stage_in.alu_result;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      out_valid <= 1'b0;
    else
      out_valid <= stage_in.valid;
  end

  always_ff @(posedge clk)
  begin
    out_rd   <= stage_in.rd;
    out_data <= wb_data;
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build tb_exec_unit with Verilator and run it; exit status follows the testbench
cd "$(dirname "$0")" &&
  verilator --binary --timing --top-module tb_exec_unit -f exec_unit.f -o sim_exec_unit &&
  ./obj_dir/sim_exec_unit ||
  { echo "exec_unit build or run did not succeed" >&2; exit 1; }

// File: tests/tb_exec_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_exec_unit: random testbench for the integer execute block
// clock, reset, stimulus, reference model, checker and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "exec_params.svh"

module tb_exec_unit;
  import exec_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_RANDOM   = 2000;
  localparam int NUM_CORNER   = 5;
  localparam int LATENCY      = `BOOTH_STEPS + 2;
  localparam int TEST_CYCLES  = RESET_CYCLES + NUM_CORNER * NUM_CORNER + NUM_RANDOM;
  localparam int WATCHDOG_NS  = (TEST_CYCLES + `BOOTH_STEPS + 10) * 10;

  logic                   clk;
  logic                   reset;
  logic                   in_valid;
  logic [`XLEN-1:0]       inst;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic                   out_valid;
  logic [`REG_ADDR_W-1:0] out_rd;
  logic [`XLEN-1:0]       out_data;

  logic [31:0] edge_count = '0;  // rising edges so far
  logic [31:0] exp_rd[$];
  logic [31:0] exp_data[$];
  logic [31:0] exp_edge[$];      // edge count at which the result is due
  logic [31:0] mul_corners [NUM_CORNER] =
    '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

  exec_unit_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .inst      (inst),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .out_valid (out_valid),
    .out_rd    (out_rd),
    .out_data  (out_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
    edge_count <= edge_count + 32'd1;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t: %s was %08h, expected %08h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  // reference model from the instruction set rules
  function automatic logic [31:0] model_result(input logic [31:0] ins, input logic [31:0] a,
                                               input logic [31:0] rs2);
    logic [6:0]  f7;
    logic [31:0] b;
    logic [63:0] prod;
    alu_op_e     op;
    f7 = ins[31:25];
    b  = rs2;
    if (ins[6:0] == OP_IMM)
    begin
      if (ins[14:12] == 3'b001 || ins[14:12] == 3'b101)
        b = {27'd0, ins[24:20]};  // shamt
      else
      begin
        b  = {{20{ins[31]}}, ins[31:20]};
        f7 = 7'd0;
      end
    end
    case (ins[14:12])
      3'b000:  op = f7[5] ? ALU_SUB : (f7[0] ? ALU_MUL : ALU_ADD);
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = f7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // 64-bit signed product
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $signed(a) >>> b[4:0];
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      default:  return prod[31:0];
    endcase
  endfunction

  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = $urandom();
    if (r[2:0] < 3'd5)
      return mul_corners[r[2:0]];  // corner values fairly often
    return $urandom();
  endfunction

  function automatic logic [31:0] random_inst();
    logic [31:0] r;
    logic [31:0] r2;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    int unsigned kind;
    r    = $urandom();
    r2   = $urandom();
    kind = $urandom_range(0, 9);
    f3   = r[2:0];
    rd   = (r[7:4] == 4'd0) ? 5'd0 : r[12:8];  // x0 now and then
    f7   = 7'd0;
    if (kind == 0)
    begin
      opc = r[19:13];
      while (opc == OP_COMPUTE || opc == OP_IMM)
        opc = opc + 7'd1;
    end
    else if (kind <= 3)
    begin
      opc = OP_COMPUTE;
      if (f3 == 3'b000 || f3 == 3'b101)
        f7 = r[20] ? 7'h20 : 7'h00;
    end
    else if (kind <= 5)
    begin
      opc = OP_COMPUTE;  // mul
      f3  = 3'b000;
      f7  = 7'h01;
    end
    else
    begin
      opc = OP_IMM;
      if (f3 == 3'b101)
        f7 = r[20] ? 7'h20 : 7'h00;
      else if (f3 != 3'b001)
        f7 = r[31:25];  // upper immediate bits
    end
    return {f7, r2[4:0], r2[9:5], f3, rd, opc};
  endfunction

  // drive one cycle of input and queue what should come out
  task automatic drive_cycle(input logic valid, input logic [31:0] ins,
                             input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    @(posedge clk);
    #1;
    in_valid = valid;
    inst     = ins;
    rs1_data = a;
    rs2_data = b;
    if (valid && (ins[6:0] == OP_COMPUTE || ins[6:0] == OP_IMM))
    begin
      res = (ins[11:7] == 5'd0) ? 32'd0 : model_result(ins, a, b);
      exp_rd.push_back({27'd0, ins[11:7]});
      exp_data.push_back(res);
      exp_edge.push_back(edge_count + LATENCY);
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk)
  begin
    if (edge_count != 0 && out_valid !== 1'b0)
    begin
      if (exp_edge.size() == 0)
      begin
        $display("out_valid went high at %0t with no instruction in flight", $time);
        $display("Simulation FAILED");
        $fatal(1, "unexpected output");
      end
      else
      begin
        check_value("output edge", edge_count, exp_edge.pop_front());
        check_value("rd", {27'd0, out_rd}, exp_rd.pop_front());
        check_value("data", out_data, exp_data.pop_front());
      end
    end
    else if (exp_edge.size() != 0 && exp_edge[0] <= edge_count)
      check_value("out_valid", {31'd0, out_valid}, 32'd1);
  end

  initial
  begin
    logic [31:0] r;
    logic [4:0]  mul_rd;
    void'($urandom(32'h7569_ad8b));
    reset     = 1'b1;
    in_valid  = 1'b0;
    inst      = '0;
    rs1_data  = '0;
    rs2_data  = '0;
    mul_rd    = 5'd1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    // every corner value against every other one back to back
    for (int i = 0; i < NUM_CORNER; i++)
      for (int j = 0; j < NUM_CORNER; j++)
      begin
        drive_cycle(1'b1, {7'h01, 5'd2, 5'd1, 3'b000, mul_rd, OP_COMPUTE},
                    mul_corners[i], mul_corners[j]);
        mul_rd = mul_rd + 5'd1;
      end
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      r = $urandom();
      drive_cycle(r[2:0] != 3'd0, random_inst(), pick_operand(), pick_operand());
    end
    drive_cycle(1'b0, 32'd0, 32'd0, 32'd0);
    repeat (LATENCY + 2) @(posedge clk);  // drain the pipe
    #1;
    if (exp_edge.size() == 0)
    begin
      $display("Simulation PASSED");
      $finish;
    end
    else
    begin
      $display("%0d results never came out of the pipe", exp_edge.size());
      $display("Simulation FAILED");
      $fatal(1, "missing results");
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("The run timed out after %0d ns", WATCHDOG_NS);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: verilog/exec_unit_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// exec_unit_top: stand-alone integer execute block
// decode, unrolled booth pipeline and writeback, fixed latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_unit_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,   // one instruction per strobe
  input  logic [`XLEN-1:0]       inst,
  input  logic [`XLEN-1:0]       rs1_data,
  input  logic [`XLEN-1:0]       rs2_data,
  output logic                   out_valid,  // no back-pressure, consume on sight
  output logic [`REG_ADDR_W-1:0] out_rd,
  output logic [`XLEN-1:0]       out_data
);

  // stage[0] from decode, stage[BOOTH_STEPS] into writeback
  booth_if stage [`BOOTH_STEPS+1] ();

  op_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .inst      (inst),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .stage_out (stage[0])
  );

  // one step per multiplier bit
  genvar i;
  generate
    for (i = 0; i < `BOOTH_STEPS; i = i + 1)
    begin : g_step
      booth_step u_step (
        .clk       (clk),
        .reset     (reset),
        .stage_in  (stage[i]),
        .stage_out (stage[i+1])
      );
    end
  endgenerate

  result_writeback u_writeback (
    .clk       (clk),
    .reset     (reset),
    .stage_in  (stage[`BOOTH_STEPS]),
    .out_valid (out_valid),
    .out_rd    (out_rd),
    .out_data  (out_data)
  );

endmodule
